//--- project.f
src/rv_isa_pkg.sv
src/core_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile.sv
src/hazard_unit.sv
src/execute_unit.sv
src/datamem.sv
src/core.sv
tb/core_chk.sv
tb/core_tb.sv

//--- tb/core_tb.sv
/* Core testbench
   Assembles small programs, loads them during reset and checks every
   retire against a queue built from the ISA rules */
`timescale 1ns/1ns

module core_tb;
	import core_pkg::*;
	import rv_isa_pkg::*;

	typedef struct packed {
		pc_t      pc;
		reg_idx_t rd;
		word_t    val;
	} retire_t;

	logic       clk;
	logic       rst_n;
	logic       prog_we;
	pc_t        prog_addr;
	word_t      prog_data;
	logic       con_write;
	dmem_addr_t con_addr;
	word_t      con_in;
	word_t      con_out;
	logic       retire_valid;
	reg_idx_t   retire_rd;
	word_t      retire_data;
	pc_t        retire_pc;

	word_t   prog [$];   // Program image being built
	retire_t exp_q [$];  // Expected retires in order
	word_t   xr [32];    // Architectural registers
	word_t   dm [int];   // Data words by word index
	int      dead;       // Instructions still to be squashed
	int      errors;
	int      checks;
	int      tests;
	int      err_mark;   // errors at start of the current test

	core uut (.*);

	bind core core_chk chk (
		.clk, .rst_n, .con_write, .con_addr, .con_in, .con_out,
		.core_we(ex_mem_write), .core_alu(ex_alu_result),
		.retire_valid, .retire_rd, .retire_pc
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Program building with a reference model
	function automatic word_t sext12(logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	task automatic new_program();
		prog.delete();
		exp_q.delete();
		foreach (xr[i])
			xr[i] = '0;  // Core reset clears the registers
		dead = 0;
		err_mark = errors;
	endtask

	// Append one word, update the model unless it gets squashed
	task automatic emit(word_t inst, reg_idx_t rd, word_t val, logic wr);
		pc_t pc;
		pc = pc_t'(prog.size() * 4);
		prog.push_back(inst);
		if (dead > 0) begin
			dead--;
		end else if (wr && rd != '0) begin
			xr[rd] = val;
			exp_q.push_back(retire_t'{pc, rd, val});
		end
	endtask

	task automatic alu_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
			reg_idx_t rs2);
		word_t a;
		word_t b;
		word_t r;
		a = xr[rs1];
		b = xr[rs2];
		case (f3)
			F3_ADD:  r = (f7 == F7_SUB) ? a - b : a + b;
			F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_XOR:  r = a ^ b;
			F3_OR:   r = a | b;
			default: r = a & b;
		endcase
		emit({f7, rs2, rs1, f3, rd, OPC_RTYPE}, rd, r, 1'b1);
	endtask

	task automatic addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		emit({imm, rs1, F3_ADD, rd, OPC_ITYPE}, rd, xr[rs1] + sext12(imm), 1'b1);
	endtask

	task automatic lui(reg_idx_t rd, logic [19:0] imm);
		emit({imm, rd, OPC_LUI}, rd, {imm, 12'b0}, 1'b1);
	endtask

	task automatic sw(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
		word_t addr;
		addr = xr[rs1] + sext12(imm);
		if (dead == 0)
			dm[addr[DMEM_BITS+1:2]] = xr[rs2];
		emit({imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE}, '0, '0, 1'b0);
	endtask

	task automatic lw(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		word_t addr;
		addr = xr[rs1] + sext12(imm);
		emit({imm, rs1, F3_WORD, rd, OPC_LOAD}, rd, dm[addr[DMEM_BITS+1:2]], 1'b1);
	endtask

	// Always jumps over the next two words when taken
	task automatic branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
		logic [12:0] off;
		logic        live;
		logic        taken;
		off   = 13'd12;
		live  = (dead == 0);
		taken = (xr[rs1] == xr[rs2]) != (f3 == F3_BNE);
		emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH}, '0, '0, 1'b0);
		if (live && taken)
			dead = 2;
	endtask

	task automatic jal(reg_idx_t rd, logic [20:0] off);
		logic live;
		pc_t  pc;
		live = (dead == 0);
		pc   = pc_t'(prog.size() * 4);
		emit({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL}, rd,
			word_t'(pc) + 32'd4, 1'b1);
		if (live && off != '0)
			dead = int'(off) / 4 - 1;
	endtask

	task automatic halt();
		jal(5'd0, 21'd0);  // Spin in place, no retire
	endtask

	//////////////////////////////////////////////////
	// Load and run
	task automatic load_program();
		@(posedge clk);
		#1 rst_n = 1'b0;
		for (int i = 0; i < 10; i++) begin
			prog_we   = 1'b1;
			prog_addr = pc_t'(i * 4);
			prog_data = (i < prog.size()) ? prog[i] : NOP_INST;
			@(posedge clk);
			#1;
		end
		prog_we = 1'b0;
		rst_n   = 1'b1;
	endtask

	task automatic check_retires(string name);
		retire_t e;
		int      waited;
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!retire_valid && waited < 50);
			if (!retire_valid) begin
				$display("%s: no retire of x%0d from pc %0h within 50 cycles", name, e.rd, e.pc);
				errors++;
				break;
			end
			checks++;
			assert (retire_pc == e.pc && retire_rd == e.rd && retire_data == e.val) else begin
				$display("FAILED %0t: %s x%0d pc %0h value %h, expected x%0d pc %0h value %h",
					$time, name, retire_rd, retire_pc, retire_data, e.rd, e.pc, e.val);
				errors++;
			end
		end
		// Program is parked on its halt loop
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			assert (!retire_valid) else begin
				$display("%s: unexpected retire of x%0d from pc %0h", name, retire_rd, retire_pc);
				errors++;
			end
		end
	endtask

	task automatic end_test(string name);
		tests++;
		if (errors == err_mark)
			$display("[%0d] %s: ok", tests, name);
		else
			$display("[%0d] %s: %0d errors", tests, name, errors - err_mark);
	endtask

	//////////////////////////////////////////////////
	initial begin
		logic [11:0] ra;
		logic [11:0] rb;
		logic [19:0] ru;
		word_t       cv;
		int          total;
		void'($urandom(74));
		rst_n     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = NOP_INST;
		con_write = 1'b0;
		con_addr  = '0;
		con_in    = '0;
		errors    = 0;
		checks    = 0;
		tests     = 0;

		// Dependent ALU chain
		new_program();
		ra = $urandom;
		rb = $urandom;
		ru = $urandom;
		addi(1, 0, ra);
		addi(2, 1, rb);                // x1 from MEM
		alu_r(7'b0, F3_ADD, 3, 1, 2);  // WB and MEM
		alu_r(F7_SUB, F3_ADD, 4, 3, 1);
		alu_r(7'b0, F3_XOR, 5, 4, 2);
		alu_r(7'b0, F3_OR, 6, 5, 3);
		alu_r(7'b0, F3_AND, 7, 6, 4);
		alu_r(7'b0, F3_SLT, 8, 7, 1);
		lui(9, ru);
		halt();
		load_program();
		check_retires("alu_chain");
		end_test("alu_chain");

		// Store, load and load-use
		new_program();
		rb = $urandom;
		addi(1, 0, 12'd64);
		addi(2, 0, rb);
		sw(2, 1, 12'd4);
		lw(3, 1, 12'd4);
		alu_r(7'b0, F3_ADD, 4, 3, 2);  // One bubble
		halt();
		load_program();
		check_retires("store_load");
		@(posedge clk);
		#1 con_addr = dmem_addr_t'(17);  // Byte address 68
		@(posedge clk);
		@(negedge clk);
		checks++;
		assert (con_out == dm[17]) else begin
			$display("FAILED %0t: con_out word 17 read %h, expected %h", $time, con_out, dm[17]);
			errors++;
		end
		end_test("store_load");

		// Controller write, core load
		new_program();
		cv = $urandom;
		@(posedge clk);
		#1;
		con_write = 1'b1;
		con_addr  = dmem_addr_t'(40);
		con_in    = cv;
		@(posedge clk);
		#1 con_write = 1'b0;
		dm[40] = cv;
		addi(1, 0, 12'd160);
		lw(5, 1, 12'd0);
		addi(6, 5, 12'd1);
		halt();
		load_program();
		check_retires("con_load");
		end_test("con_load");

		// Taken BNE and BEQ
		new_program();
		ra = $urandom_range(1, 2047);
		rb = $urandom;
		addi(1, 0, ra);
		branch(F3_BNE, 1, 0);
		addi(10, 0, 12'd99);  // Squashed
		addi(11, 0, 12'd98);
		addi(2, 1, 12'd0);    // Target
		branch(F3_BEQ, 1, 2);
		addi(12, 0, 12'd97);
		addi(13, 0, 12'd96);
		addi(3, 2, rb);
		halt();
		load_program();
		check_retires("taken_branch");
		end_test("taken_branch");

		// Fall-through and JAL
		new_program();
		ra = $urandom_range(1, 2047);
		addi(1, 0, ra);
		branch(F3_BEQ, 1, 0);  // Not taken
		branch(F3_BNE, 1, 1);
		addi(2, 1, 12'd1);
		jal(5, 21'd12);
		addi(14, 0, 12'd95);
		addi(15, 0, 12'd94);
		addi(6, 5, 12'd3);     // Link read through the WB bypass
		halt();
		load_program();
		check_retires("jal_fallthrough");
		end_test("jal_fallthrough");

		// Writes to x0
		new_program();
		ra = $urandom;
		ru = $urandom;
		addi(1, 0, 12'd5);
		addi(0, 1, ra);
		lui(0, ru);
		alu_r(7'b0, F3_ADD, 2, 0, 0);
		alu_r(7'b0, F3_ADD, 3, 0, 1);
		halt();
		load_program();
		check_retires("x0_write");
		end_test("x0_write");

		total = errors + uut.chk.fail_count;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, checks, errors, uut.chk.fail_count);
		if (total == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- tb/core_chk.sv
/* Core protocol checker
   Concurrent assertions on the retire strobe and the controller port,
   bound into the core */
`timescale 1ns/1ns

module core_chk (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 con_write,
	input  core_pkg::dmem_addr_t con_addr,
	input  core_pkg::word_t      con_in,
	input  core_pkg::word_t      con_out,
	input  logic                 core_we,    // Core store in EX
	input  core_pkg::word_t      core_alu,   // Store byte address
	input  logic                 retire_valid,
	input  core_pkg::reg_idx_t   retire_rd,
	input  core_pkg::pc_t        retire_pc
);
	import core_pkg::*;

	int         fail_count;  // Read by the testbench at the end
	dmem_addr_t core_addr;

	initial fail_count = 0;

	assign core_addr = core_alu[DMEM_BITS+1:2];  // Word index, as in datamem

	//////////////////////////////////////////////////
	// Retire strobe
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !retire_valid)
		else begin
			$error("retire_valid high right after a reset cycle");
			fail_count++;
		end

	// Pipeline fill, nothing reaches WB for four edges
	fill_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid [*4])
		else begin
			$error("retire_valid high during pipeline fill");
			fail_count++;
		end

	rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> retire_rd != '0)
		else begin
			$error("retire with rd of x0");
			fail_count++;
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> retire_pc[1:0] == 2'b00)
		else begin
			$error("retire_pc %h not word aligned", retire_pc);
			fail_count++;
		end

	//////////////////////////////////////////////////
	// Controller port, write-first readback
	con_readback: assert property (@(posedge clk) disable iff (!rst_n)
		(con_write && !(core_we && core_addr == con_addr)) |=> con_out == $past(con_in))
		else begin
			$error("con_out %h differs from the word just written", con_out);
			fail_count++;
		end

endmodule

//--- src/core.sv
/* Five-stage RV32I core
   IF, ID, EX, MEM and WB with forwarding into execute, load-use stall,
   branch flush, a controller port on data memory and a retire strobe */
`timescale 1ns/1ns

module core (
	input  logic                 clk,
	input  logic                 rst_n,
	// Program load, only while in reset
	input  logic                 prog_we,
	input  core_pkg::pc_t        prog_addr,
	input  core_pkg::word_t      prog_data,
	// Controller port
	input  logic                 con_write,
	input  core_pkg::dmem_addr_t con_addr,
	input  core_pkg::word_t      con_in,
	output core_pkg::word_t      con_out,
	// Retire strobe
	output logic                 retire_valid,
	output core_pkg::reg_idx_t   retire_rd,
	output core_pkg::word_t      retire_data,
	output core_pkg::pc_t        retire_pc
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	// IF
	pc_t      if_pc;
	word_t    if_inst;
	// ID
	word_t    id_inst;
	pc_t      id_pc;
	reg_idx_t id_rs1, id_rs2, id_rd;
	word_t    id_imm, id_rd1, id_rd2;
	alu_op_t  id_alu_op;
	wb_sel_t  id_wb_sel;
	logic     id_use_imm, id_reg_write, id_mem_read, id_mem_write;
	logic     id_is_branch, id_branch_ne, id_is_jal;
	// Hazard controls
	logic     stall, flush_id, flush_ex;
	fwd_sel_t fwd_a, fwd_b;
	// EX
	pc_t      ex_pc;
	word_t    ex_rs1_val, ex_rs2_val, ex_imm;
	reg_idx_t ex_rs1, ex_rs2, ex_rd;
	alu_op_t  ex_alu_op;
	wb_sel_t  ex_wb_sel;
	logic     ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
	logic     ex_is_branch, ex_branch_ne, ex_is_jal;
	word_t    ex_alu_result, ex_store_data;
	logic     redirect;
	pc_t      redirect_pc;
	// MEM
	pc_t      mem_pc;
	word_t    mem_alu, mem_load, mem_fwd;
	reg_idx_t mem_rd;
	wb_sel_t  mem_wb_sel;
	logic     mem_reg_write;
	// WB
	pc_t      wb_pc;
	word_t    wb_alu, wb_load, wb_data;
	reg_idx_t wb_rd;
	wb_sel_t  wb_wb_sel;
	logic     wb_reg_write;

	// Result select, shared by MEM forwarding and WB
	function automatic word_t result_mux(wb_sel_t sel, word_t alu, word_t load, pc_t pc);
		case (sel)
			WB_LOAD: return load;
			WB_PC4:  return word_t'(pc) + 32'd4;  // JAL link
			default: return alu;
		endcase
	endfunction

	fetch_unit u_fetch (
		.clk, .rst_n, .stall, .redirect, .redirect_pc,
		.prog_we, .prog_addr, .prog_data, .if_pc, .if_inst
	);

	//////////////////////////////////////////////////
	// IF/ID
	always_ff @(posedge clk) begin
		if (!rst_n || flush_id)
			id_inst <= NOP_INST;
		else if (!stall)
			id_inst <= if_inst;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			id_pc <= if_pc;
	end

	decoder u_dec (
		.inst(id_inst), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
		.alu_op(id_alu_op), .use_imm(id_use_imm), .reg_write(id_reg_write),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .is_branch(id_is_branch),
		.branch_ne(id_branch_ne), .is_jal(id_is_jal), .wb_sel(id_wb_sel)
	);

	regfile u_rf (
		.clk, .rst_n, .rs1(id_rs1), .rs2(id_rs2),
		.wr_en(wb_reg_write), .wr_rd(wb_rd), .wr_data(wb_data),
		.rd1(id_rd1), .rd2(id_rd2)
	);

	hazard_unit u_hazard (
		.id_rs1, .id_rs2, .ex_rs1, .ex_rs2, .ex_rd, .ex_mem_read,
		.mem_rd, .mem_reg_write, .wb_rd, .wb_reg_write, .redirect,
		.fwd_a, .fwd_b, .stall, .flush_id, .flush_ex
	);

	//////////////////////////////////////////////////
	// ID/EX, bubble on load-use or redirect
	always_ff @(posedge clk) begin
		if (!rst_n || flush_ex) begin
			ex_rs1       <= '0;
			ex_rs2       <= '0;
			ex_rd        <= '0;
			ex_alu_op    <= ALU_ADD;
			ex_wb_sel    <= WB_ALU;
			ex_use_imm   <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_is_branch <= 1'b0;
			ex_branch_ne <= 1'b0;
			ex_is_jal    <= 1'b0;
		end else begin
			ex_rs1       <= id_rs1;
			ex_rs2       <= id_rs2;
			ex_rd        <= id_rd;
			ex_alu_op    <= id_alu_op;
			ex_wb_sel    <= id_wb_sel;
			ex_use_imm   <= id_use_imm;
			ex_reg_write <= id_reg_write;
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_is_branch <= id_is_branch;
			ex_branch_ne <= id_branch_ne;
			ex_is_jal    <= id_is_jal;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc      <= id_pc;
		ex_rs1_val <= id_rd1;
		ex_rs2_val <= id_rd2;
		ex_imm     <= id_imm;
	end

	execute_unit u_exec (
		.pc(ex_pc), .rs1_val(ex_rs1_val), .rs2_val(ex_rs2_val), .imm(ex_imm),
		.alu_op(ex_alu_op), .use_imm(ex_use_imm), .is_branch(ex_is_branch),
		.branch_ne(ex_branch_ne), .is_jal(ex_is_jal), .fwd_a, .fwd_b,
		.mem_fwd, .wb_fwd(wb_data), .alu_result(ex_alu_result),
		.store_data(ex_store_data), .redirect, .redirect_pc
	);

	// Addressed from EX so load data is ready in MEM
	datamem u_dmem (
		.clk, .rst_n, .we(ex_mem_write), .addr(ex_alu_result[DMEM_BITS+1:2]),
		.wdata(ex_store_data), .con_write, .con_addr, .con_in,
		.rdata(mem_load), .con_out
	);

	//////////////////////////////////////////////////
	// EX/MEM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_rd        <= '0;
			mem_wb_sel    <= WB_ALU;
			mem_reg_write <= 1'b0;
		end else begin
			mem_rd        <= ex_rd;
			mem_wb_sel    <= ex_wb_sel;
			mem_reg_write <= ex_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		mem_pc  <= ex_pc;
		mem_alu <= ex_alu_result;
	end

	assign mem_fwd = result_mux(mem_wb_sel, mem_alu, mem_load, mem_pc);

	//////////////////////////////////////////////////
	// MEM/WB and writeback
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_rd        <= '0;
			wb_wb_sel    <= WB_ALU;
			wb_reg_write <= 1'b0;
		end else begin
			wb_rd        <= mem_rd;
			wb_wb_sel    <= mem_wb_sel;
			wb_reg_write <= mem_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		wb_pc   <= mem_pc;
		wb_alu  <= mem_alu;
		wb_load <= mem_load;
	end

	assign wb_data = result_mux(wb_wb_sel, wb_alu, wb_load, wb_pc);

	// One pulse per architectural register write
	assign retire_valid = wb_reg_write;  // Decode already drops x0 writes
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_data;
	assign retire_pc    = wb_pc;

endmodule

//--- src/datamem.sv
/* Data memory
   Word array with a core port and an outside controller port,
   each with a registered write-first read */
`timescale 1ns/1ns

module datamem (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 we,
	input  core_pkg::dmem_addr_t addr,
	input  core_pkg::word_t      wdata,
	input  logic                 con_write,
	input  core_pkg::dmem_addr_t con_addr,
	input  core_pkg::word_t      con_in,
	output core_pkg::word_t      rdata,
	output core_pkg::word_t      con_out
);
	import core_pkg::*;

	word_t mem [2**DMEM_BITS];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			if (con_write)
				mem[con_addr] <= con_in;
			if (we)
				mem[addr] <= wdata;  // Issued last so the core wins a collision
		end
	end

	// Read registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata   <= '0;
			con_out <= '0;
		end else begin
			rdata   <= we ? wdata : mem[addr];
			con_out <= con_write ? con_in : mem[con_addr];
		end
	end

endmodule

//--- src/execute_unit.sv
/* Execute stage
   Forwarding muxes, ALU and branch or jump resolution */
`timescale 1ns/1ns

module execute_unit (
	input  core_pkg::pc_t      pc,
	input  core_pkg::word_t    rs1_val,
	input  core_pkg::word_t    rs2_val,
	input  core_pkg::word_t    imm,
	input  core_pkg::alu_op_t  alu_op,
	input  logic               use_imm,
	input  logic               is_branch,
	input  logic               branch_ne,
	input  logic               is_jal,
	input  core_pkg::fwd_sel_t fwd_a,
	input  core_pkg::fwd_sel_t fwd_b,
	input  core_pkg::word_t    mem_fwd,     // Result sitting in MEM
	input  core_pkg::word_t    wb_fwd,      // Result sitting in WB
	output core_pkg::word_t    alu_result,
	output core_pkg::word_t    store_data,
	output logic               redirect,
	output core_pkg::pc_t      redirect_pc
);
	import core_pkg::*;

	word_t op_a, op_b, b_val;
	logic  equal;

	function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val);
		case (sel)
			FWD_MEM: return mem_fwd;
			FWD_WB:  return wb_fwd;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a  = fwd_pick(fwd_a, rs1_val);
		b_val = fwd_pick(fwd_b, rs2_val);
		op_b  = use_imm ? imm : b_val;
		case (alu_op)
			ALU_SUB:   alu_result = op_a - op_b;
			ALU_AND:   alu_result = op_a & op_b;
			ALU_OR:    alu_result = op_a | op_b;
			ALU_XOR:   alu_result = op_a ^ op_b;
			ALU_SLT:   alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_PASSB: alu_result = op_b;
			default:   alu_result = op_a + op_b;  // Also load/store address
		endcase
	end

	assign store_data = b_val;  // SW data after forwarding
	assign equal      = (op_a == b_val);

	// BNE takes on inequality, BEQ on equality
	assign redirect    = is_jal || (is_branch && (equal != branch_ne));
	assign redirect_pc = pc + imm[PC_BITS-1:0];

endmodule

//--- src/hazard_unit.sv
/* Hazard unit
   Execute operand forwarding, load-use stall and branch flush */
`timescale 1ns/1ns

module hazard_unit (
	input  core_pkg::reg_idx_t id_rs1,
	input  core_pkg::reg_idx_t id_rs2,
	input  core_pkg::reg_idx_t ex_rs1,
	input  core_pkg::reg_idx_t ex_rs2,
	input  core_pkg::reg_idx_t ex_rd,
	input  logic               ex_mem_read,
	input  core_pkg::reg_idx_t mem_rd,
	input  logic               mem_reg_write,
	input  core_pkg::reg_idx_t wb_rd,
	input  logic               wb_reg_write,
	input  logic               redirect,
	output core_pkg::fwd_sel_t fwd_a,
	output core_pkg::fwd_sel_t fwd_b,
	output logic               stall,
	output logic               flush_id,
	output logic               flush_ex
);
	import core_pkg::*;

	logic load_use;

	// Youngest producer wins, x0 never forwarded
	function automatic fwd_sel_t pick_src(reg_idx_t src);
		if (src == '0)
			return FWD_NONE;
		if (mem_reg_write && mem_rd == src)
			return FWD_MEM;
		if (wb_reg_write && wb_rd == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = pick_src(ex_rs1);
		fwd_b = pick_src(ex_rs2);
	end

	// Load data is only ready in MEM, so hold decode one cycle
	assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	assign stall    = load_use;
	assign flush_id = redirect;             // Squash fetched slot
	assign flush_ex = redirect || load_use; // Bubble or squash into ID/EX

endmodule

//--- src/regfile.sv
/* Integer register file
   31 writable registers, x0 reads as zero, WB write bypassed to reads */
`timescale 1ns/1ns

module regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	input  logic               wr_en,
	input  core_pkg::reg_idx_t wr_rd,
	input  core_pkg::word_t    wr_data,
	output core_pkg::word_t    rd1,
	output core_pkg::word_t    rd2
);
	import core_pkg::*;

	word_t regs [1:31];  // No storage for x0

	function automatic word_t read_port(reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (wr_en && wr_rd == idx)
			return wr_data;  // Same-cycle write seen in decode
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_rd != '0) begin
			regs[wr_rd] <= wr_data;
		end
	end

	always_comb begin
		rd1 = read_port(rs1);
		rd2 = read_port(rs2);
	end

endmodule

//--- src/decoder.sv
/* Instruction decoder
   Maps the reduced RV32I subset to stage controls and builds the
   sign-extended immediate; anything unknown decodes as a NOP */
`timescale 1ns/1ns

module decoder (
	input  core_pkg::word_t    inst,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output core_pkg::reg_idx_t rd,
	output core_pkg::word_t    imm,
	output core_pkg::alu_op_t  alu_op,
	output logic               use_imm,
	output logic               reg_write,
	output logic               mem_read,
	output logic               mem_write,
	output logic               is_branch,
	output logic               branch_ne,
	output logic               is_jal,
	output core_pkg::wb_sel_t  wb_sel
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	opc_t       opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       use_rs1, use_rs2;  // Source fields are real registers
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[F3_LSB +: 3];
	assign funct7 = inst[F7_LSB +: 7];
	assign rd     = inst[RD_LSB +: 5];

	// Unused source fields read as x0 so they never match a hazard
	assign rs1 = use_rs1 ? inst[RS1_LSB +: 5] : '0;
	assign rs2 = use_rs2 ? inst[RS2_LSB +: 5] : '0;

	//////////////////////////////////////////////////
	// Immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		// NOP unless a known encoding matches
		alu_op    = ALU_ADD;
		imm       = '0;
		use_imm   = 1'b0;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jal    = 1'b0;
		wb_sel    = WB_ALU;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		case (opcode)
			OPC_RTYPE: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				reg_write = (funct7 == 7'b0) || (funct7 == F7_SUB && funct3 == F3_ADD);
				case (funct3)
					F3_ADD:  alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_SLT:  alu_op = ALU_SLT;
					F3_XOR:  alu_op = ALU_XOR;
					F3_OR:   alu_op = ALU_OR;
					F3_AND:  alu_op = ALU_AND;
					default: reg_write = 1'b0;  // Shifts and SLTU not kept
				endcase
			end
			OPC_ITYPE: if (funct3 == F3_ADD) begin  // ADDI only
				use_rs1   = 1'b1;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				imm       = imm_i;
			end
			OPC_LUI: begin
				alu_op    = ALU_PASSB;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				imm       = imm_u;
			end
			OPC_LOAD: if (funct3 == F3_WORD) begin
				use_rs1   = 1'b1;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				mem_read  = 1'b1;
				wb_sel    = WB_LOAD;
				imm       = imm_i;
			end
			OPC_STORE: if (funct3 == F3_WORD) begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;  // Store data
				use_imm   = 1'b1;
				mem_write = 1'b1;
				imm       = imm_s;
			end
			OPC_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				is_branch = 1'b1;
				branch_ne = (funct3 == F3_BNE);
				imm       = imm_b;
			end
			OPC_JAL: begin
				is_jal    = 1'b1;
				reg_write = 1'b1;
				wb_sel    = WB_PC4;
				imm       = imm_j;
			end
			default: ;  // Unknown opcode
		endcase
		if (rd == '0)
			reg_write = 1'b0;  // x0 writes drop here
	end

endmodule

//--- src/fetch_unit.sv
/* Fetch stage
   PC register with hold and redirect, and the instruction memory
   with a load port used while the core sits in reset */
`timescale 1ns/1ns

module fetch_unit (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,        // Hold PC for load-use
	input  logic            redirect,     // Taken branch or JAL in execute
	input  core_pkg::pc_t   redirect_pc,
	input  logic            prog_we,
	input  core_pkg::pc_t   prog_addr,
	input  core_pkg::word_t prog_data,
	output core_pkg::pc_t   if_pc,
	output core_pkg::word_t if_inst
);
	import core_pkg::*;

	word_t imem [IMEM_WORDS];  // Word addressed

	// PC register
	always_ff @(posedge clk) begin
		if (!rst_n)
			if_pc <= '0;  // Boot vector
		else if (redirect)
			if_pc <= redirect_pc;
		else if (!stall)
			if_pc <= if_pc + pc_t'(4);
	end

	// Program load port
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr[PC_BITS-1:2]] <= prog_data;
	end

	assign if_inst = imem[if_pc[PC_BITS-1:2]];  // Async read

endmodule

//--- src/core_pkg.sv
/* Core micro-architecture types
   Data and address widths, stage control codes and memory sizes */
package core_pkg;

	localparam int XLEN    = 32;
	localparam int PC_BITS = 12;  // 4 KB of instruction space

	typedef logic [XLEN-1:0]    word_t;
	typedef logic [PC_BITS-1:0] pc_t;     // Byte address
	typedef logic [4:0]         reg_idx_t;

	// ALU select
	typedef logic [2:0] alu_op_t;
	localparam alu_op_t ALU_ADD   = 3'd0;
	localparam alu_op_t ALU_SUB   = 3'd1;
	localparam alu_op_t ALU_AND   = 3'd2;
	localparam alu_op_t ALU_OR    = 3'd3;
	localparam alu_op_t ALU_XOR   = 3'd4;
	localparam alu_op_t ALU_SLT   = 3'd5;
	localparam alu_op_t ALU_PASSB = 3'd6;  // LUI

	// Writeback source
	typedef logic [1:0] wb_sel_t;
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_LOAD = 2'd1;
	localparam wb_sel_t WB_PC4  = 2'd2;  // JAL link

	// Execute operand source
	typedef logic [1:0] fwd_sel_t;
	localparam fwd_sel_t FWD_NONE = 2'd0;
	localparam fwd_sel_t FWD_MEM  = 2'd1;
	localparam fwd_sel_t FWD_WB   = 2'd2;

	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_BITS  = 8;  // 256 data words
	typedef logic [DMEM_BITS-1:0] dmem_addr_t;

endpackage

//--- src/rv_isa_pkg.sv
/* RV32I encoding constants
   Opcodes, funct codes and field positions for the reduced subset */
package rv_isa_pkg;

	typedef logic [6:0] opc_t;  // Major opcode

	// Major opcodes
	localparam opc_t OPC_RTYPE  = 7'b0110011;
	localparam opc_t OPC_ITYPE  = 7'b0010011;
	localparam opc_t OPC_LUI    = 7'b0110111;
	localparam opc_t OPC_LOAD   = 7'b0000011;
	localparam opc_t OPC_STORE  = 7'b0100011;
	localparam opc_t OPC_BRANCH = 7'b1100011;
	localparam opc_t OPC_JAL    = 7'b1101111;

	// funct3 codes
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_WORD = 3'b010;  // LW and SW width

	localparam logic [6:0] F7_SUB = 7'b0100000;

	// Low bit of each register and funct field
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB  = 25;

	localparam logic [31:0] NOP_INST = 32'h0000_0013;  // ADDI x0, x0, 0

endpackage
